/* build.f */
common/mipsPkg.sv
hw/controlDecoder.sv
hw/cycleSequencer.sv
hw/pcUnit.sv
datapath/regFile.sv
datapath/alu.sv
hw/mipsCore.sv
dv/mipsCore_props.sv
dv/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the result from the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module mipsCoreTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "sim passed" sim.log

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ns

module mipsCoreTb;

  logic            clk;
  logic            reset;
  logic            ack;
  mipsPkg::busResp memResp;
  logic            req;
  mipsPkg::busReq  memReq;
  logic            retired;

  logic [31:0]    mem [256];
  logic [31:0]    storeAddr [$];
  logic [31:0]    storeData [$];
  mipsPkg::busReq fetchLog [$];
  integer         seed = 29158;
  int             maxDelay;
  int             delay;
  logic           busy;

  mipsCore i_mipsCore (
    .clk(clk), .reset(reset), .ack(ack), .memResp(memResp), .req(req),
    .memReq(memReq), .retired(retired)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory model, answers each request after a random delay.
  always @(negedge clk) begin
    if (reset) begin
      ack = 1'b0;
      busy = 1'b0;
    end else if (ack) begin
      if (!req) ack = 1'b0;
    end else if (req) begin
      if (!busy) begin
        busy = 1'b1;
        delay = $unsigned($random(seed)) % (maxDelay + 1);
      end
      if (delay > 0) begin
        delay = delay - 1;
      end else begin
        busy = 1'b0;
        if (memReq.write) begin
          mem[memReq.addr[9:2]] = memReq.wdata;
          storeAddr.push_back(memReq.addr);
          storeData.push_back(memReq.wdata);
        end else begin
          memResp.rdata = mem[memReq.addr[9:2]];
          fetchLog.push_back(memReq);
        end
        ack = 1'b1;
      end
    end
  end

  function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                       mipsPkg::functE fn);
    return {mipsPkg::opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(mipsPkg::opcodeE op, logic [4:0] rs, logic [4:0] rt,
                                       logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(mipsPkg::opcodeE op, logic [25:0] index);
    return {op, index};
  endfunction

  task automatic failNow(string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic checkWord(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      failNow($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Reads compare address and direction only, their wdata is a don't care.
  task automatic checkBus(string name, mipsPkg::busReq expected, mipsPkg::busReq actual);
    if (expected.addr !== actual.addr || expected.write !== actual.write ||
        (expected.write && expected.wdata !== actual.wdata)) begin
      failNow($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic checkStore(string name, int idx, logic [31:0] addr, logic [31:0] data);
    if (idx >= storeAddr.size()) failNow($sformatf("%s: store %0d never happened", name, idx));
    checkWord(name, addr, storeAddr[idx]);
    checkWord(name, data, storeData[idx]);
  endtask

  task automatic checkFetch(string name, int idx, logic [31:0] addr);
    mipsPkg::busReq expected;
    expected = '{addr: addr, wdata: 32'd0, write: 1'b0};
    if (idx >= fetchLog.size()) failNow($sformatf("%s: fetch %0d never happened", name, idx));
    checkBus(name, expected, fetchLog[idx]);
  endtask

  task automatic clearMem();
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hFC00_0000 | 32'(i); // Unknown opcode, tagged with its word address.
    end
  endtask

  task automatic runProgram(string name, int count);
    int seen;
    int cycles;
    seen = 0;
    cycles = 0;
    reset = 1'b1;
    repeat (5) @(negedge clk);
    storeAddr.delete();
    storeData.delete();
    fetchLog.delete();
    reset = 1'b0;
    while (seen < count) begin
      @(negedge clk);
      if (retired) seen++;
      cycles++;
      if (cycles > 4000) failNow($sformatf("%s: timeout waiting for retired", name));
    end
  endtask

  task automatic rtypeTest(string name, int delayLimit);
    logic [31:0] a;
    logic [31:0] b;
    a = 32'd7;
    b = 32'hFFFF_FFFD;
    maxDelay = delayLimit;
    clearMem();
    mem[0] = encI(mipsPkg::opAddi, 5'd0, 5'd1, a[15:0]);
    mem[1] = encI(mipsPkg::opAddi, 5'd0, 5'd2, b[15:0]);
    mem[2] = encI(mipsPkg::opAddi, 5'd0, 5'd0, 16'd5); // Register 0 must ignore this.
    mem[3] = encR(5'd1, 5'd2, 5'd3, mipsPkg::fnAdd);
    mem[4] = encR(5'd1, 5'd2, 5'd4, mipsPkg::fnSub);
    mem[5] = encR(5'd1, 5'd2, 5'd5, mipsPkg::fnAnd);
    mem[6] = encR(5'd1, 5'd2, 5'd6, mipsPkg::fnOr);
    mem[7] = encR(5'd2, 5'd1, 5'd7, mipsPkg::fnSlt);
    mem[8] = encR(5'd1, 5'd2, 5'd8, mipsPkg::fnSlt);
    for (int r = 0; r < 6; r++) begin
      mem[9 + r] = encI(mipsPkg::opSw, 5'd0, 5'(r + 3), 16'(16'h100 + 4 * r));
    end
    mem[15] = encI(mipsPkg::opSw, 5'd0, 5'd0, 16'h118);
    mem[16] = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hFFFF);
    runProgram(name, 16);
    checkStore(name, 0, 32'h100, a + b);
    checkStore(name, 1, 32'h104, a - b);
    checkStore(name, 2, 32'h108, a & b);
    checkStore(name, 3, 32'h10C, a | b);
    checkStore(name, 4, 32'h110, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
    checkStore(name, 5, 32'h114, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    checkStore(name, 6, 32'h118, 32'd0);
  endtask

  task automatic loadImmTest();
    maxDelay = 3;
    clearMem();
    mem[128] = 32'h1234_5678;
    mem[129] = 32'hFFFF_F0F0;
    mem[0] = encI(mipsPkg::opLw, 5'd0, 5'd1, 16'h200);
    mem[1] = encI(mipsPkg::opLw, 5'd0, 5'd2, 16'h204);
    mem[2] = encI(mipsPkg::opAddi, 5'd0, 5'd3, 16'hFF9C);
    mem[3] = encI(mipsPkg::opAndi, 5'd2, 5'd4, 16'h8F0F);
    mem[4] = encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h100);
    mem[5] = encI(mipsPkg::opSw, 5'd0, 5'd2, 16'h104);
    mem[6] = encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h108);
    mem[7] = encI(mipsPkg::opSw, 5'd0, 5'd4, 16'h10C);
    mem[8] = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hFFFF);
    runProgram("loadImm", 8);
    checkStore("loadImm", 0, 32'h100, 32'h1234_5678);
    checkStore("loadImm", 1, 32'h104, 32'hFFFF_F0F0);
    checkStore("loadImm", 2, 32'h108, 32'd0 - 32'd100);
    checkStore("loadImm", 3, 32'h10C, 32'hFFFF_F0F0 & 32'h0000_8F0F);
  endtask

  task automatic branchTest();
    maxDelay = 3;
    clearMem();
    mem[0] = encI(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5);
    mem[1] = encI(mipsPkg::opAddi, 5'd0, 5'd2, 16'd5);
    mem[2] = encI(mipsPkg::opBeq, 5'd1, 5'd2, 16'd1);
    mem[3] = encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h100); // Skipped.
    mem[4] = encI(mipsPkg::opBne, 5'd1, 5'd2, 16'd1);
    mem[5] = encI(mipsPkg::opAddi, 5'd0, 5'd3, 16'd9);
    mem[6] = encI(mipsPkg::opBeq, 5'd1, 5'd3, 16'd1);
    mem[7] = encI(mipsPkg::opBne, 5'd1, 5'd3, 16'd1);
    mem[8] = encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h104); // Skipped.
    mem[9] = encI(mipsPkg::opSw, 5'd0, 5'd3, 16'h108);
    mem[10] = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hFFFF);
    runProgram("branch", 9);
    checkFetch("branch", 0, 32'h00);
    checkFetch("branch", 1, 32'h04);
    checkFetch("branch", 2, 32'h08);
    checkFetch("branch", 3, 32'h08 + 32'd4 + 32'd4); // beq taken.
    checkFetch("branch", 4, 32'h10 + 32'd4);         // bne not taken.
    checkFetch("branch", 5, 32'h18);
    checkFetch("branch", 6, 32'h18 + 32'd4);         // beq not taken.
    checkFetch("branch", 7, 32'h1C + 32'd4 + 32'd4); // bne taken.
    checkFetch("branch", 8, 32'h28);
    if (storeAddr.size() != 1) failNow("branch: a store in skipped code was executed");
    checkStore("branch", 0, 32'h108, 32'd9);
  endtask

  task automatic jumpTest();
    maxDelay = 3;
    clearMem();
    mem[0] = encI(mipsPkg::opAddi, 5'd0, 5'd1, 16'd1);
    mem[1] = encJ(mipsPkg::opJal, 26'h4);
    mem[2] = encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h104);
    mem[3] = encJ(mipsPkg::opJ, 26'h8);
    mem[4] = encI(mipsPkg::opSw, 5'd0, 5'd31, 16'h100);
    mem[5] = encR(5'd31, 5'd0, 5'd0, mipsPkg::fnJr);
    mem[6] = encI(mipsPkg::opSw, 5'd0, 5'd1, 16'h108); // Never reached.
    mem[8] = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hFFFF);
    runProgram("jump", 7);
    checkFetch("jump", 0, 32'h00);
    checkFetch("jump", 1, 32'h04);
    checkFetch("jump", 2, 32'h10);
    checkFetch("jump", 3, 32'h14);
    checkFetch("jump", 4, 32'h04 + 32'd4); // jr returns after the jal.
    checkFetch("jump", 5, 32'h0C);
    checkFetch("jump", 6, 32'h20);
    if (storeAddr.size() != 2) failNow("jump: wrong number of stores");
    checkStore("jump", 0, 32'h100, 32'h04 + 32'd4);
    checkStore("jump", 1, 32'h104, 32'd1);
  endtask

  initial begin
    reset = 1'b1;
    ack = 1'b0;
    memResp = '0;
    busy = 1'b0;
    delay = 0;
    maxDelay = 3;
    clearMem();
    rtypeTest("rtype", 3);
    loadImmTest();
    branchTest();
    jumpTest();
    rtypeTest("backPressure", 10);
    $display("sim passed");
    $finish;
  end

endmodule

/* dv/mipsCore_props.sv */
`timescale 1ns/1ns

module mipsCoreProps (
  input logic           clk,
  input logic           reset,
  input logic           req,
  input logic           ack,
  input mipsPkg::busReq memReq,
  input logic           retired
);

  // A pending request holds its address and data until the memory answers.
  reqStable: assert property (@(posedge clk) disable iff (reset)
    req && !ack |=> req && $stable(memReq))
    else $error("request dropped or changed before ack");

  // A new request waits until the previous ack has gone low.
  reqAfterAckLow: assert property (@(posedge clk) disable iff (reset)
    $rose(req) |-> !$past(ack))
    else $error("request raised while ack still high");

  reqLowAfterReset: assert property (@(posedge clk) reset |=> !req)
    else $error("request high in the cycle after reset");

  retiredPulse: assert property (@(posedge clk) disable iff (reset)
    retired |=> !retired)
    else $error("retired high for two cycles in a row");

endmodule

bind mipsCore mipsCoreProps i_mipsCoreProps (
  .clk(clk),
  .reset(reset),
  .req(req),
  .ack(ack),
  .memReq(memReq),
  .retired(retired)
);

/* hw/mipsCore.sv */
`timescale 1ns/1ns

module mipsCore (
  input  logic            clk,
  input  logic            reset,
  input  logic            ack,
  input  mipsPkg::busResp memResp,
  output logic            req,
  output mipsPkg::busReq  memReq,
  output logic            retired
);

  mipsPkg::ctrlSignals ctrl;
  mipsPkg::seqStateE   state;
  logic [31:0] instr;
  logic [31:0] mdr;
  logic        irLoad;
  logic        mdrLoad;
  logic        pcAdvance;
  logic        regWe;
  logic        zero;
  logic        memPhase;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [31:0] rsValue;
  logic [31:0] rtValue;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic [31:0] regWdata;
  logic [4:0]  regWaddr;

  cycleSequencer i_cycleSequencer (
    .clk(clk), .reset(reset), .ctrl(ctrl), .ack(ack), .state(state), .req(req),
    .irLoad(irLoad), .mdrLoad(mdrLoad), .pcAdvance(pcAdvance), .regWe(regWe),
    .retired(retired)
  );

  controlDecoder i_controlDecoder (.instr(instr), .ctrl(ctrl));

  pcUnit i_pcUnit (
    .clk(clk), .reset(reset), .pcAdvance(pcAdvance), .instr(instr), .ctrl(ctrl),
    .zero(zero), .rsValue(rsValue), .pc(pc), .pcPlus4(pcPlus4)
  );

  regFile i_regFile (
    .clk(clk), .reset(reset), .we(regWe), .waddr(regWaddr), .wdata(regWdata),
    .raddrA(instr[25:21]), .raddrB(instr[20:16]), .rdataA(rsValue), .rdataB(rtValue)
  );

  alu i_alu (.a(rsValue), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(zero));

  always_ff @(posedge clk) begin
    if (irLoad) instr <= memResp.rdata;
    if (mdrLoad) mdr <= memResp.rdata;
  end

  always_comb begin
    if (!ctrl.aluSrcImm) begin
      aluB = rtValue;
    end else if (ctrl.immZeroExt) begin
      aluB = {16'd0, instr[15:0]};
    end else begin
      aluB = {{16{instr[15]}}, instr[15:0]};
    end
  end

  // jal links to register 31 with the address after itself.
  assign regWaddr = ctrl.jal ? mipsPkg::linkReg : (ctrl.regDst ? instr[15:11] : instr[20:16]);
  assign regWdata = ctrl.jal ? pcPlus4 : (ctrl.memToReg ? mdr : aluResult);

  assign memPhase = (state == mipsPkg::memReq) || (state == mipsPkg::memRelease);

  // Address and data hold steady while the request is up.
  assign memReq.addr = memPhase ? aluResult : pc;
  assign memReq.wdata = rtValue;
  assign memReq.write = memPhase & ctrl.memWrite;

endmodule

/* datapath/alu.sv */
`timescale 1ns/1ns

module alu (
  input  logic [31:0]    a,
  input  logic [31:0]    b,
  input  mipsPkg::aluOpE op,
  output logic [31:0]    result,
  output logic           zero
);

  always_comb begin
    case (op)
      mipsPkg::aluAdd: result = a + b;
      mipsPkg::aluSub: result = a - b;
      mipsPkg::aluAnd: result = a & b;
      mipsPkg::aluOr:  result = a | b;
      mipsPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)}; // Signed compare.
      default:         result = a + b;
    endcase
  end

  // Branches compare through a subtraction and test this flag.
  assign zero = (result == 32'd0);

endmodule

/* datapath/regFile.sv */
`timescale 1ns/1ns

module regFile (
  input  logic        clk,
  input  logic        reset,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic [4:0]  raddrA,
  input  logic [4:0]  raddrB,
  output logic [31:0] rdataA,
  output logic [31:0] rdataB
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata; // Writes to register 0 are dropped.
    end
  end

  // Reads are combinational.
  assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
  assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

/* hw/pcUnit.sv */
`timescale 1ns/1ns

module pcUnit (
  input  logic                clk,
  input  logic                reset,
  input  logic                pcAdvance,
  input  logic [31:0]         instr,
  input  mipsPkg::ctrlSignals ctrl,
  input  logic                zero,
  input  logic [31:0]         rsValue,
  output logic [31:0]         pc,
  output logic [31:0]         pcPlus4
);

  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic        taken;

  assign pcPlus4 = pc + mipsPkg::pcStep;
  assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
  assign taken = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= mipsPkg::resetPc;
    end else if (pcAdvance) begin
      if (ctrl.jr) begin
        pc <= rsValue;
      end else if (ctrl.jump) begin
        pc <= jumpTarget;
      end else if (taken) begin
        pc <= branchTarget;
      end else begin
        pc <= pcPlus4;
      end
    end
  end

endmodule

/* hw/cycleSequencer.sv */
`timescale 1ns/1ns

module cycleSequencer (
  input  logic                clk,
  input  logic                reset,
  input  mipsPkg::ctrlSignals ctrl,
  input  logic                ack,
  output mipsPkg::seqStateE   state,
  output logic                req,
  output logic                irLoad,
  output logic                mdrLoad,
  output logic                pcAdvance,
  output logic                regWe,
  output logic                retired
);

  mipsPkg::seqStateE nextState;
  logic memOp;
  logic lastCycle;

  assign memOp = ctrl.memToReg | ctrl.memWrite;

  always_comb begin
    nextState = state;
    irLoad = 1'b0;
    mdrLoad = 1'b0;
    pcAdvance = 1'b0;
    regWe = 1'b0;
    lastCycle = 1'b0;
    case (state)
      mipsPkg::fetchReq: begin
        irLoad = ack; // Capture on the first cycle ack is seen.
        if (ack) nextState = mipsPkg::fetchRelease;
      end
      mipsPkg::fetchRelease: begin
        if (!ack) nextState = mipsPkg::execute;
      end
      mipsPkg::execute: begin
        pcAdvance = 1'b1;
        regWe = ctrl.regWrite & ~ctrl.memToReg;
        lastCycle = ~memOp;
        nextState = memOp ? mipsPkg::memReq : mipsPkg::fetchReq;
      end
      mipsPkg::memReq: begin
        mdrLoad = ack;
        if (ack) nextState = mipsPkg::memRelease;
      end
      mipsPkg::memRelease: begin
        if (!ack) begin
          lastCycle = ~ctrl.memToReg; // A store ends here.
          nextState = ctrl.memToReg ? mipsPkg::writeback : mipsPkg::fetchReq;
        end
      end
      mipsPkg::writeback: begin
        regWe = 1'b1;
        lastCycle = 1'b1;
        nextState = mipsPkg::fetchReq;
      end
      default: nextState = mipsPkg::fetchReq;
    endcase
  end

  // The request follows the next state, so it stays low right after reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mipsPkg::fetchReq;
      req <= 1'b0;
      retired <= 1'b0;
    end else begin
      state <= nextState;
      req <= (nextState == mipsPkg::fetchReq) || (nextState == mipsPkg::memReq);
      retired <= lastCycle;
    end
  end

endmodule

/* hw/controlDecoder.sv */
`timescale 1ns/1ns

module controlDecoder (
  input  logic [31:0]         instr,
  output mipsPkg::ctrlSignals ctrl
);

  mipsPkg::opcodeE opcode;
  mipsPkg::functE  funct;

  assign opcode = mipsPkg::opcodeE'(instr[31:26]);
  assign funct = mipsPkg::functE'(instr[5:0]);

  always_comb begin
    ctrl = '0;
    ctrl.aluOp = mipsPkg::aluAdd; // Unknown encodings fall back to this.
    case (opcode)
      mipsPkg::opRType: begin
        case (funct)
          mipsPkg::fnAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
          end
          mipsPkg::fnSub: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
            ctrl.aluOp = mipsPkg::aluSub;
          end
          mipsPkg::fnAnd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
            ctrl.aluOp = mipsPkg::aluAnd;
          end
          mipsPkg::fnOr: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
            ctrl.aluOp = mipsPkg::aluOr;
          end
          mipsPkg::fnSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
            ctrl.aluOp = mipsPkg::aluSlt;
          end
          mipsPkg::fnJr: ctrl.jr = 1'b1; // No register write for jr.
          default: ;
        endcase
      end
      mipsPkg::opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      mipsPkg::opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        ctrl.branchEq = 1'b1;
        ctrl.aluOp = mipsPkg::aluSub;
      end
      mipsPkg::opBne: begin
        ctrl.branchNe = 1'b1;
        ctrl.aluOp = mipsPkg::aluSub;
      end
      mipsPkg::opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      mipsPkg::opAndi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.immZeroExt = 1'b1; // Logical immediates are zero extended.
        ctrl.aluOp = mipsPkg::aluAnd;
      end
      mipsPkg::opJ: ctrl.jump = 1'b1;
      mipsPkg::opJal: begin
        ctrl.regWrite = 1'b1;
        ctrl.jump = 1'b1;
        ctrl.jal = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

/* common/mipsPkg.sv */
package mipsPkg;

  // Primary opcode field, instr[31:26].
  typedef enum logic [5:0] {
    opRType = 6'b000000,
    opJ     = 6'b000010,
    opJal   = 6'b000011,
    opBeq   = 6'b000100,
    opBne   = 6'b000101,
    opAddi  = 6'b001000,
    opAndi  = 6'b001100,
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcodeE;

  // Funct field of R-type instructions, instr[5:0].
  typedef enum logic [5:0] {
    fnJr  = 6'b001000,
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } functE;

  typedef enum logic [2:0] {
    aluAnd = 3'b000,
    aluOr  = 3'b001,
    aluAdd = 3'b010,
    aluSub = 3'b110,
    aluSlt = 3'b111
  } aluOpE;

  typedef enum logic [2:0] {
    fetchReq,
    fetchRelease,
    execute,
    memReq,
    memRelease,
    writeback
  } seqStateE;

  typedef struct packed {
    logic  memToReg;
    logic  memWrite;
    logic  branchNe;
    logic  branchEq;
    logic  aluSrcImm;
    logic  immZeroExt;
    logic  regDst;
    logic  regWrite;
    logic  jump;
    logic  jal;
    logic  jr;
    aluOpE aluOp;
  } ctrlSignals;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        write;
  } busReq;

  typedef struct packed {
    logic [31:0] rdata;
  } busResp;

  localparam logic [31:0] resetPc = 32'h0000_0000; // First fetch address.
  localparam logic [31:0] pcStep = 32'd4;
  localparam logic [4:0] linkReg = 5'd31;

endpackage
